/* filelist.f */
src/cart_pkg.sv
src/cart_header_scan.sv
src/cart_quirk_table.sv
src/region_select.sv
src/cheat_code_loader.sv
src/cart_loader_top.sv
bench/tb_cart_loader.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the cart loader testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

LOG=sim.log
status=0

verilator --binary --timing --assert -f filelist.f --top-module tb_cart_loader -o sim_tb
./obj_dir/sim_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
	exit 1
elif grep -q "Verification passed" "$LOG"; then
	exit 0
else
	echo "Simulation ended without a result (exit status $status)"
	exit 1
fi

/* bench/tb_cart_loader.sv */
// Testbench for the cart loader: clock, reset, random stimulus, reference model, checks
`timescale 1ns/1ps

module tb_cart_loader;

	logic                   clk_sys;
	logic                   RESET;
	cart_pkg::dl_bus_t      dl;
	cart_pkg::key_evt_t     key;
	cart_pkg::region_cfg_t  region_cfg;
	cart_pkg::region_t      region_req;
	logic                   region_set;
	cart_pkg::cart_quirks_t quirks;
	cart_pkg::gun_cfg_t     gun_cfg;
	cart_pkg::cheat_code_t  cheat;
	logic                   cheat_valid;
	logic                   cheat_reset;

	cart_pkg::region_t  exp_req;   // Model of the region outputs
	logic               exp_set;
	cart_pkg::cart_id_t cur_id;    // ID of the cart being downloaded
	logic [7:0]         letters [4];

	////////////////////////////////////////////////////////////////////////////
	// Reference tables

	logic [63:0] quirk_ids [24] = '{
		"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ",
		"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
		"00004076", "T-12046 ", "T-12053 ", "G-4524  ", "T-113016",
		"T-89016 ", "T-574023", "T-574013", "MK-1229 ", "G-7001  ",
		"T-35036 ", "T-25073 ", "MK-1137-", "T-68???-"};
	// Bit 7 sram down to bit 0 schan
	logic [7:0] quirk_masks [24] = '{
		8'h80, 8'h80, 8'h80, 8'h80, 8'h80,
		8'h40, 8'h40, 8'h40, 8'h40, 8'h40,
		8'h40, 8'h40, 8'h40, 8'h40, 8'h20,
		8'h10, 8'h08, 8'h08, 8'h04, 8'h04,
		8'h02, 8'h02, 8'h02, 8'h01};
	logic [63:0] gun_ids [5] = '{"MK-1533 ", "T-95096-", "T-95136-", "MK-1658 ", "T-081156"};
	logic [8:0]  gun_vals [5] = '{{1'b0, 8'd100}, {1'b1, 8'd52}, {1'b1, 8'd30},
		{1'b0, 8'd120}, {1'b0, 8'd126}};

	logic [7:0] letter_pool [7] = '{"J", "U", "E", "B", "8", " ", "a"};
	logic [8:0] key_codes [4] = '{9'h005, 9'h006, 9'h004, 9'h00C}; // Last one is no F-key

	cart_loader_top dut_i (
		.clk_sys(clk_sys), .RESET(RESET), .dl(dl), .key(key), .region_cfg(region_cfg),
		.region_req(region_req), .region_set(region_set), .quirks(quirks),
		.gun_cfg(gun_cfg), .cheat(cheat), .cheat_valid(cheat_valid), .cheat_reset(cheat_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic expect_equal(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at time %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Verification failed");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1; // Drive point after the edge
	endtask

	task automatic write_word(input cart_pkg::dl_addr_t a, input cart_pkg::dl_word_t d);
		dl.wr = 1'b1;
		dl.addr = a;
		dl.data = d;
		next_cycle();
		dl.wr = 1'b0;
	endtask

	// {j, u, e} for one header byte
	function automatic logic [2:0] letter_flags(input logic [7:0] c);
		logic is_j;
		logic is_u;
		is_j = c == "J";
		is_u = c == "U";
		return {is_j, is_u, !is_j && !is_u && c >= "0" && c <= "Z"};
	endfunction

	// Walk the order backwards so the best flagged region wins
	function automatic cart_pkg::region_t header_region(input cart_pkg::region_prio_t p,
			input logic [2:0] jue);
		cart_pkg::region_t order [3];
		cart_pkg::region_t r;
		case (p)
			cart_pkg::PRIO_US_EU_JP: order = '{cart_pkg::US, cart_pkg::EU, cart_pkg::JP};
			cart_pkg::PRIO_EU_US_JP: order = '{cart_pkg::EU, cart_pkg::US, cart_pkg::JP};
			cart_pkg::PRIO_US_JP_EU: order = '{cart_pkg::US, cart_pkg::JP, cart_pkg::EU};
			default:                 order = '{cart_pkg::JP, cart_pkg::US, cart_pkg::EU};
		endcase
		r = order[0];
		for (int i = 2; i >= 0; i--) begin
			if ((order[i] == cart_pkg::JP && jue[2]) || (order[i] == cart_pkg::US && jue[1]) ||
					(order[i] == cart_pkg::EU && jue[0]))
				r = order[i];
		end
		return r;
	endfunction

	function automatic logic [7:0] expect_quirks(input cart_pkg::cart_id_t id);
		logic [7:0] m;
		m = 8'h00;
		for (int i = 0; i < 24; i++)
			if (quirk_ids[i] == id)
				m = quirk_masks[i];
		return m;
	endfunction

	function automatic logic [8:0] expect_gun(input cart_pkg::cart_id_t id);
		logic [8:0] g;
		g = {1'b0, 8'd44}; // No light gun
		for (int i = 0; i < 5; i++)
			if (gun_ids[i] == id)
				g = gun_vals[i];
		return g;
	endfunction

	// ROM byte: ID text from 0x183, region letters at 0x1F0..0x1F3, else noise
	function automatic logic [7:0] hdr_byte(input cart_pkg::dl_addr_t a);
		logic [7:0] b;
		int         k;
		b = 8'($urandom);
		k = 32'h18A - int'(a);
		if (a >= 25'h183 && a <= 25'h18A)
			b = cur_id[8 * k +: 8];
		else if (a >= 25'h1F0 && a <= 25'h1F3)
			b = letters[a[1:0]];
		return b;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus sequences

	task automatic load_cart();
		cart_pkg::dl_addr_t     a;
		cart_pkg::region_mode_t mode;
		cart_pkg::region_prio_t prio;
		cart_pkg::dl_index_t    idx;
		logic [2:0]             jue;
		int                     pick;
		pick = int'($urandom % 3);
		if (pick == 0)
			cur_id = quirk_ids[$urandom % 24];
		else if (pick == 1)
			cur_id = gun_ids[$urandom % 5];
		else
			for (int k = 0; k < 8; k++)
				cur_id[8 * k +: 8] = 8'("A" + $urandom % 26);
		for (int i = 0; i < 4; i++)
			letters[i] = letter_pool[$urandom % 7];
		jue = letter_flags(letters[0]) | letter_flags(letters[1]) | letter_flags(letters[2]);
		mode = cart_pkg::region_mode_t'($urandom % 3);
		prio = cart_pkg::region_prio_t'($urandom % 4);
		idx[7:6] = 2'($urandom % 3); // Region field never 3
		idx[5:0] = 6'($urandom);
		if (idx == 8'h00)
			idx = 8'h01;
		region_cfg.mode = mode;
		region_cfg.prio = prio;
		dl.active = 1'b1;
		dl.index = idx;
		next_cycle();
		expect_equal("quirks", 128'(quirks), 128'(0)); // Cleared at download start

		for (a = '0; a <= cart_pkg::HDR_END_ADDR; a = a + 25'd2) begin
			if ($urandom % 8 == 0)
				next_cycle(); // Idle gap in the stream
			write_word(a, {hdr_byte(a + 25'd1), hdr_byte(a)});
			if (a == 25'h18C) begin
				expect_equal("quirks", 128'(quirks), 128'(expect_quirks(cur_id)));
				expect_equal("gun_cfg", 128'(gun_cfg), 128'(expect_gun(cur_id)));
			end
		end

		next_cycle(); // hdr_ready seen by region_select
		if (mode == cart_pkg::HEADER) begin
			exp_set = 1'b1;
			exp_req = header_region(prio, jue);
		end else if (mode == cart_pkg::FILE_EXT) begin
			exp_set = 1'b1; // Index is never zero here
			exp_req = cart_pkg::region_t'(idx[7:6]);
		end
		expect_equal("region_set", 128'(region_set), 128'(exp_set));
		expect_equal("region_req", 128'(region_req), 128'(exp_req));

		dl.active = 1'b0;
		next_cycle();
		next_cycle();
		exp_set = 1'b0; // Falls after download end
		expect_equal("region_set", 128'(region_set), 128'(exp_set));
		expect_equal("region_req", 128'(region_req), 128'(exp_req));
	endtask

	task automatic load_cheats(input int codes);
		cart_pkg::dl_word_t    w [8];
		cart_pkg::cheat_code_t exp_code;
		dl.active = 1'b1;
		dl.index = 8'hFF;
		next_cycle();
		for (int c = 0; c < codes; c++) begin
			for (int i = 0; i < 8; i++) begin
				w[i] = 16'($urandom);
				write_word(25'(c * 16 + i * 2), w[i]);
				expect_equal("cheat_reset", 128'(cheat_reset), 128'(c == 0 && i == 0));
				expect_equal("cheat_valid", 128'(cheat_valid), 128'(i == 7));
			end
			// Fields flags, addr, compare, replace with the low word sent first
			exp_code = {w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
			expect_equal("cheat", 128'(cheat), 128'(exp_code));
		end
		dl.active = 1'b0;
		next_cycle();
		expect_equal("cheat_valid", 128'(cheat_valid), 128'(0));
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		key.code = code;
		key.pressed = pressed;
		key.toggle = ~key.toggle;
		next_cycle();
		if (code inside {9'h004, 9'h005, 9'h006})
			exp_set = pressed;
		if (code == 9'h005)
			exp_req = cart_pkg::JP;
		else if (code == 9'h006)
			exp_req = cart_pkg::US;
		else if (code == 9'h004)
			exp_req = cart_pkg::EU;
		expect_equal("region_req", 128'(region_req), 128'(exp_req));
		expect_equal("region_set", 128'(region_set), 128'(exp_set));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		void'($urandom(32'h8240));
		RESET = 1'b1;
		dl = '0;
		key = '0;
		region_cfg = '0;
		exp_req = cart_pkg::JP;
		exp_set = 1'b0;
		repeat (16) @(posedge clk_sys);
		#1;
		RESET = 1'b0;
		next_cycle();
		expect_equal("region_set", 128'(region_set), 128'(0));
		expect_equal("quirks", 128'(quirks), 128'(0));
		expect_equal("gun_cfg", 128'(gun_cfg), 128'({1'b0, 8'd44}));
		expect_equal("cheat_valid", 128'(cheat_valid), 128'(0));
		expect_equal("cheat_reset", 128'(cheat_reset), 128'(0));

		repeat (16) load_cart();
		repeat (3) load_cheats(2);
		repeat (12) send_key(key_codes[$urandom % 4], 1'($urandom));
		repeat (8) load_cart();

		$display("Verification passed");
		$finish;
	end

endmodule

/* src/cart_loader_top.sv */
// Cart loader top level: download decode and block interconnect
`timescale 1ns/1ps

module cart_loader_top (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  cart_pkg::dl_bus_t      dl,
	input  cart_pkg::key_evt_t     key,
	input  cart_pkg::region_cfg_t  region_cfg,
	output cart_pkg::region_t      region_req,
	output logic                   region_set,
	output cart_pkg::cart_quirks_t quirks,
	output cart_pkg::gun_cfg_t     gun_cfg,
	output cart_pkg::cheat_code_t  cheat,
	output logic                   cheat_valid,
	output logic                   cheat_reset
);

	logic               cheat_file;
	logic               cart_active;
	logic               cart_wr;
	logic               cheat_wr;
	logic               lookup;
	logic               hdr_j;
	logic               hdr_u;
	logic               hdr_e;
	logic               hdr_ready;
	cart_pkg::cart_id_t cart_id;

	////////////////////////////////////////////////////////////////////////////
	// Download decode

	assign cheat_file  = dl.index == cart_pkg::CHEAT_INDEX;
	assign cart_active = dl.active && !cheat_file;
	assign cart_wr     = cart_active && dl.wr;
	assign cheat_wr    = dl.active && dl.wr && cheat_file;
	assign lookup      = cart_wr && dl.addr == cart_pkg::ID_LOOKUP_ADDR; // ID complete

	////////////////////////////////////////////////////////////////////////////
	// Blocks

	cart_header_scan hdr_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_active(cart_active), .cart_wr(cart_wr),
		.addr(dl.addr), .data(dl.data),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e),
		.hdr_ready(hdr_ready), .cart_id(cart_id)
	);

	cart_quirk_table quirk_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.cart_active(cart_active), .lookup(lookup), .cart_id(cart_id),
		.quirks(quirks), .gun_cfg(gun_cfg)
	);

	region_select region_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.hdr_ready(hdr_ready), .hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e),
		.file_index(dl.index), .cfg(region_cfg), .key(key),
		.region_req(region_req), .region_set(region_set)
	);

	cheat_code_loader cheat_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.code_wr(cheat_wr), .addr(dl.addr), .data(dl.data),
		.code(cheat), .code_valid(cheat_valid), .code_reset(cheat_reset)
	);

endmodule

/* src/cheat_code_loader.sv */
// Cheat code assembler: 128-bit code from eight words, valid and reset pulses
`timescale 1ns/1ps

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  code_wr,
	input  cart_pkg::dl_addr_t    addr,
	input  cart_pkg::dl_word_t    data,
	output cart_pkg::cheat_code_t code,
	output logic                  code_valid,
	output logic                  code_reset
);

	// Word placement, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (addr[3:0])
				4'd0:  code.flags[15:0]    <= data;
				4'd2:  code.flags[31:16]   <= data;
				4'd4:  code.addr[15:0]     <= data;
				4'd6:  code.addr[31:16]    <= data;
				4'd8:  code.compare[15:0]  <= data;
				4'd10: code.compare[31:16] <= data;
				4'd12: code.replace[15:0]  <= data;
				4'd14: code.replace[31:16] <= data; // Completes the code
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_valid <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			code_valid <= code_wr && addr[3:0] == cart_pkg::CHEAT_LAST_OFS;
			code_reset <= code_wr && addr == '0; // New cheat file, drop old codes
		end
	end

	// Codes are eight words apart
	assert property (@(posedge clk_sys) disable iff (RESET) code_valid |=> !code_valid)
		else $error("code_valid high on consecutive cycles");

endmodule

/* src/region_select.sv */
// Console region choice from header letters, file index or function keys
`timescale 1ns/1ps

module region_select (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  hdr_ready,
	input  logic                  hdr_j,
	input  logic                  hdr_u,
	input  logic                  hdr_e,
	input  cart_pkg::dl_index_t   file_index,
	input  cart_pkg::region_cfg_t cfg,
	input  cart_pkg::key_evt_t    key,
	output cart_pkg::region_t     region_req,
	output logic                  region_set
);

	// First flagged region in priority order, else head of that order
	function automatic cart_pkg::region_t pick_region(
		input cart_pkg::region_prio_t prio,
		input logic j,
		input logic u,
		input logic e
	);
		cart_pkg::region_t r;
		r = cart_pkg::JP;
		case (prio)
			cart_pkg::PRIO_US_EU_JP:
				r = u ? cart_pkg::US : e ? cart_pkg::EU : j ? cart_pkg::JP : cart_pkg::US;
			cart_pkg::PRIO_EU_US_JP:
				r = e ? cart_pkg::EU : u ? cart_pkg::US : j ? cart_pkg::JP : cart_pkg::EU;
			cart_pkg::PRIO_US_JP_EU:
				r = u ? cart_pkg::US : j ? cart_pkg::JP : e ? cart_pkg::EU : cart_pkg::US;
			cart_pkg::PRIO_JP_US_EU:
				r = j ? cart_pkg::JP : u ? cart_pkg::US : e ? cart_pkg::EU : cart_pkg::JP;
		endcase
		return r;
	endfunction

	logic old_ready;
	logic old_toggle;
	logic key_event;

	assign key_event = key.toggle != old_toggle;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_ready <= 1'b0;
			old_toggle <= key.toggle; // No phantom event out of reset
			region_req <= cart_pkg::JP;
			region_set <= 1'b0;
		end else begin
			old_ready <= hdr_ready;
			old_toggle <= key.toggle;

			if (key_event) begin
				case (key.code)
					cart_pkg::KEY_F1: begin
						region_req <= cart_pkg::JP;
						region_set <= key.pressed;
					end
					cart_pkg::KEY_F2: begin
						region_req <= cart_pkg::US;
						region_set <= key.pressed;
					end
					cart_pkg::KEY_F3: begin
						region_req <= cart_pkg::EU;
						region_set <= key.pressed;
					end
					default: ;
				endcase
			end

			// Header complete
			if (hdr_ready && !old_ready) begin
				if (cfg.mode == cart_pkg::HEADER) begin
					region_set <= 1'b1;
					region_req <= pick_region(cfg.prio, hdr_j, hdr_u, hdr_e);
				end else if (cfg.mode == cart_pkg::FILE_EXT) begin
					region_set <= |file_index;
					region_req <= cart_pkg::region_t'(file_index[7:6]); // Region in index MSBs
				end
			end

			if (old_ready && !hdr_ready)
				region_set <= 1'b0; // Download finished
		end
	end

	assert property (@(posedge clk_sys) disable iff (RESET) region_req != 2'd3)
		else $error("Region request out of range");

endmodule

/* src/cart_quirk_table.sv */
// Product ID lookup: per-game quirk flags and light-gun settings
`timescale 1ns/1ps

module cart_quirk_table (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_active,
	input  logic                   lookup,
	input  cart_pkg::cart_id_t     cart_id,
	output cart_pkg::cart_quirks_t quirks,
	output cart_pkg::gun_cfg_t     gun_cfg
);

	logic old_active;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_active <= 1'b0;
			quirks <= '0;
			gun_cfg <= '{gun_type: 1'b0, sensor_delay: cart_pkg::DEFAULT_SENSOR_DELAY};
		end else begin
			old_active <= cart_active;
			if (cart_active && !old_active)
				quirks <= '0; // Fresh download

			if (lookup) begin
				case (cart_id)
					// Battery RAM mapped on odd bytes
					"T-081276", "T-81406 ", "T-081586", "T-81576 ", "T-81476 ":
						quirks.sram <= 1'b1;
					// Serial EEPROM saves
					"MK-1215 ", "G-4060  ", "00001211", "MK-1228 ", "G-5538  ",
					"00004076", "T-12046 ", "T-12053 ", "G-4524  ":
						quirks.eeprom <= 1'b1;
					"T-113016":
						quirks.noram <= 1'b1; // Fake RAM check
					"T-89016 ":
						quirks.fifo <= 1'b1;
					"T-574023", "T-574013":
						quirks.pier <= 1'b1;
					"MK-1229 ", "G-7001  ":
						quirks.svp <= 1'b1;   // DSP cart
					"T-35036 ", "T-25073 ", "MK-1137-":
						quirks.fmbusy <= 1'b1;
					"T-68???-":
						quirks.schan <= 1'b1;
					default: ;
				endcase

				// Light-gun type and sensor offset
				case (cart_id)
					"MK-1533 ": gun_cfg <= '{1'b0, 8'd100};
					"T-95096-": gun_cfg <= '{1'b1, 8'd52};  // Justifier
					"T-95136-": gun_cfg <= '{1'b1, 8'd30};  // Justifier
					"MK-1658 ": gun_cfg <= '{1'b0, 8'd120};
					"T-081156": gun_cfg <= '{1'b0, 8'd126};
					default:    gun_cfg <= '{1'b0, cart_pkg::DEFAULT_SENSOR_DELAY};
				endcase
			end
		end
	end

	// Table entries are exclusive and flags clear per download
	assert property (@(posedge clk_sys) disable iff (RESET) $onehot0(quirks))
		else $error("More than one quirk flag set");

endmodule

/* src/cart_header_scan.sv */
// ROM header scanner: region letter flags, product ID capture, header-ready level
`timescale 1ns/1ps

module cart_header_scan (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               cart_active,
	input  logic               cart_wr,
	input  cart_pkg::dl_addr_t addr,
	input  cart_pkg::dl_word_t data,
	output logic               hdr_j,
	output logic               hdr_u,
	output logic               hdr_e,
	output logic               hdr_ready,
	output cart_pkg::cart_id_t cart_id
);

	// Region letter to {j, u, e}
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] f;
		f = 3'b000;
		if (ch == "J")
			f = 3'b100;
		else if (ch == "U")
			f = 3'b010;
		else if (ch >= "0" && ch <= "Z")
			f = 3'b001; // Anything else counts as Europe
		return f;
	endfunction

	logic       old_active;
	logic [2:0] lo_flags;
	logic [2:0] hi_flags;
	logic [2:0] new_flags;

	assign lo_flags = classify(data[7:0]);
	assign hi_flags = classify(data[15:8]);

	always_comb begin
		new_flags = 3'b000;
		if (cart_wr && addr == cart_pkg::HDR_REGION_ADDR0)
			new_flags = lo_flags | hi_flags;
		else if (cart_wr && addr == cart_pkg::HDR_REGION_ADDR1)
			new_flags = lo_flags; // Only low byte is a region letter here
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_active <= 1'b0;
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
			hdr_ready <= 1'b0;
		end else begin
			old_active <= cart_active;
			if (cart_active && !old_active)
				{hdr_j, hdr_u, hdr_e} <= new_flags; // New cart starts clean
			else
				{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | new_flags;

			if (old_active && !cart_active)
				hdr_ready <= 1'b0;
			if (cart_wr && addr == cart_pkg::HDR_END_ADDR)
				hdr_ready <= 1'b1;
		end
	end

	// Product ID, ROM bytes 0x183..0x18A, big endian across word halves
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (addr)
				cart_pkg::ID_ADDR_FIRST:         cart_id[63:56] <= data[15:8];
				cart_pkg::ID_ADDR_FIRST + 25'd2: cart_id[55:40] <= {data[7:0], data[15:8]};
				cart_pkg::ID_ADDR_FIRST + 25'd4: cart_id[39:24] <= {data[7:0], data[15:8]};
				cart_pkg::ID_ADDR_FIRST + 25'd6: cart_id[23:8]  <= {data[7:0], data[15:8]};
				cart_pkg::ID_ADDR_LAST:          cart_id[7:0]   <= data[7:0];
				default: ;
			endcase
		end
	end

	// Header end can only be seen while a cart is downloading
	assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(hdr_ready) |-> $past(cart_active))
		else $error("hdr_ready rose outside a cart download");

endmodule

/* src/cart_pkg.sv */
// Cart loader package: widths, enums, structs, header address map, cheat layout
package cart_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Vector types

	typedef logic [24:0] dl_addr_t;      // Byte address in download stream
	typedef logic [15:0] dl_word_t;      // Even byte in low half
	typedef logic [7:0]  dl_index_t;     // File index, all ones for cheats
	typedef logic [63:0] cart_id_t;      // Eight ASCII characters
	typedef logic [7:0]  sensor_delay_t; // Light-gun sensor delay
	typedef logic [31:0] cheat_field_t;

	////////////////////////////////////////////////////////////////////////////
	// ROM header map and constants

	localparam dl_addr_t HDR_REGION_ADDR0 = 25'h1F0; // Two region letters
	localparam dl_addr_t HDR_REGION_ADDR1 = 25'h1F2; // Third letter, low byte
	localparam dl_addr_t HDR_END_ADDR     = 25'h200;
	localparam dl_addr_t ID_ADDR_FIRST    = 25'h182;
	localparam dl_addr_t ID_ADDR_LAST     = 25'h18A;
	localparam dl_addr_t ID_LOOKUP_ADDR   = 25'h18C; // First word past the ID

	localparam dl_index_t     CHEAT_INDEX          = 8'hFF;
	localparam sensor_delay_t DEFAULT_SENSOR_DELAY = 8'd44;

	// Key codes for manual region change
	localparam logic [8:0] KEY_F1 = 9'h005;
	localparam logic [8:0] KEY_F2 = 9'h006;
	localparam logic [8:0] KEY_F3 = 9'h004;

	// Word offset that completes a cheat code
	localparam logic [3:0] CHEAT_LAST_OFS = 4'd14;

	////////////////////////////////////////////////////////////////////////////
	// Enums

	typedef enum logic [1:0] {JP = 2'd0, US = 2'd1, EU = 2'd2} region_t;

	typedef enum logic [1:0] {
		PRIO_US_EU_JP = 2'd0,
		PRIO_EU_US_JP = 2'd1,
		PRIO_US_JP_EU = 2'd2,
		PRIO_JP_US_EU = 2'd3
	} region_prio_t;

	typedef enum logic [1:0] {HEADER = 2'd0, FILE_EXT = 2'd1, OFF = 2'd2} region_mode_t;

	////////////////////////////////////////////////////////////////////////////
	// Structs

	typedef struct packed {
		logic      active;
		logic      wr;
		dl_index_t index;
		dl_addr_t  addr;
		dl_word_t  data;
	} dl_bus_t;

	typedef struct packed {
		logic       toggle;  // Flips once per key event
		logic       pressed;
		logic [8:0] code;
	} key_evt_t;

	typedef struct packed {
		region_mode_t mode;
		region_prio_t prio;
	} region_cfg_t;

	typedef struct packed {
		logic sram;
		logic eeprom;
		logic noram;
		logic fifo;
		logic pier;
		logic svp;
		logic fmbusy;
		logic schan;
	} cart_quirks_t;

	typedef struct packed {
		logic          gun_type;
		sensor_delay_t sensor_delay;
	} gun_cfg_t;

	// Offsets 0..14 fill flags, addr, compare, replace, low word first
	typedef struct packed {
		cheat_field_t flags;
		cheat_field_t addr;
		cheat_field_t compare;
		cheat_field_t replace;
	} cheat_code_t;

endpackage
